//--- hdl/video_trim_pkg.sv
/*
 * video trimmer shared definitions
 * pixel and coordinate widths, config opcodes, skid buffer states
 */

`default_nettype none

package video_trim_pkg;

	// ----------------------------------------------------------
	// widths
	// ----------------------------------------------------------
	// RGB888
	localparam int TDATA_WIDTH    = 24;
	localparam int X_WIDTH        = 12;
	localparam int Y_WIDTH        = 12;
	localparam int CFG_DATA_WIDTH = (X_WIDTH > Y_WIDTH) ? X_WIDTH : Y_WIDTH;

	typedef logic [TDATA_WIDTH-1:0] pixel_t;
	typedef logic [X_WIDTH-1:0]     x_coord_t;
	typedef logic [Y_WIDTH-1:0]     y_coord_t;

	// ----------------------------------------------------------
	// config write opcodes
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		CFG_ENABLE  = 3'd0,
		CFG_X_START = 3'd1,
		CFG_X_END   = 3'd2,
		CFG_Y_START = 3'd3,
		CFG_Y_END   = 3'd4,
		CFG_COMMIT  = 3'd5
	} cfg_op_e;

	// skid buffer occupancy
	typedef enum logic [1:0] {
		BUF_EMPTY = 2'd0,
		BUF_ONE   = 2'd1,
		BUF_FULL  = 2'd2
	} buf_state_e;

endpackage

`default_nettype wire

//--- hdl/trim_param_regs.sv
/*
 * trim window parameter registers
 * opcode-tagged writes land in staging registers, a commit makes them live
 */

`timescale 1ns/1ps
`default_nettype none

module trim_param_regs (
	input  wire                             aclk,
	input  wire                             aresetn,
	input  wire                             cfg_valid,
	output logic                            cfg_ready,
	input  wire video_trim_pkg::cfg_op_e    cfg_op,
	input  wire [video_trim_pkg::CFG_DATA_WIDTH-1:0] cfg_data,
	output logic                            enable,
	output video_trim_pkg::x_coord_t        x_start,
	output video_trim_pkg::x_coord_t        x_end,
	output video_trim_pkg::y_coord_t        y_start,
	output video_trim_pkg::y_coord_t        y_end
);

	logic                     stage_enable;
	video_trim_pkg::x_coord_t stage_x_start;
	video_trim_pkg::x_coord_t stage_x_end;
	video_trim_pkg::y_coord_t stage_y_start;
	video_trim_pkg::y_coord_t stage_y_end;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			cfg_ready     <= 1'b0;
			stage_enable  <= 1'b0;
			stage_x_start <= '0;
			stage_x_end   <= '0;
			stage_y_start <= '0;
			stage_y_end   <= '0;
			enable        <= 1'b0;
			x_start       <= '0;
			x_end         <= '0;
			y_start       <= '0;
			y_end         <= '0;
		end else begin
			cfg_ready <= 1'b1;
			if (cfg_valid && cfg_ready) begin
				case (cfg_op)
					video_trim_pkg::CFG_ENABLE:  stage_enable  <= cfg_data[0];
					video_trim_pkg::CFG_X_START: stage_x_start <= cfg_data[video_trim_pkg::X_WIDTH-1:0];
					video_trim_pkg::CFG_X_END:   stage_x_end   <= cfg_data[video_trim_pkg::X_WIDTH-1:0];
					video_trim_pkg::CFG_Y_START: stage_y_start <= cfg_data[video_trim_pkg::Y_WIDTH-1:0];
					video_trim_pkg::CFG_Y_END:   stage_y_end   <= cfg_data[video_trim_pkg::Y_WIDTH-1:0];
					// all five values go live on the same edge
					video_trim_pkg::CFG_COMMIT: begin
						enable  <= stage_enable;
						x_start <= stage_x_start;
						x_end   <= stage_x_end;
						y_start <= stage_y_start;
						y_end   <= stage_y_end;
					end
					default: ;
				endcase
			end
		end
	end

	// opcode must be a known member when offered
	assert property (@(posedge aclk) disable iff (!aresetn)
		cfg_valid |-> cfg_op inside {video_trim_pkg::CFG_ENABLE, video_trim_pkg::CFG_X_START,
			video_trim_pkg::CFG_X_END, video_trim_pkg::CFG_Y_START,
			video_trim_pkg::CFG_Y_END, video_trim_pkg::CFG_COMMIT})
		else $error("undefined config opcode %0d", cfg_op);

endmodule

`default_nettype wire

//--- hdl/video_trim_core.sv
/*
 * video window trim core
 * three stages: register input, count column and row, test window
 * and rebuild start-of-frame and end-of-line on the kept pixels
 */

`timescale 1ns/1ps
`default_nettype none

module video_trim_core (
	input  wire                           aclk,
	input  wire                           aresetn,
	input  wire                           enable,
	input  wire video_trim_pkg::x_coord_t x_start,
	input  wire video_trim_pkg::x_coord_t x_end,
	input  wire video_trim_pkg::y_coord_t y_start,
	input  wire video_trim_pkg::y_coord_t y_end,
	input  wire                           s_tvalid,
	input  wire video_trim_pkg::pixel_t   s_tdata,
	input  wire                           s_tuser,
	input  wire                           s_tlast,
	input  wire                           advance,
	output logic                          out_valid,
	output video_trim_pkg::pixel_t        out_tdata,
	output logic                          out_tuser,
	output logic                          out_tlast
);

	// stage 0
	logic                     st0_valid;
	video_trim_pkg::pixel_t   st0_tdata;
	logic                     st0_tuser;
	logic                     st0_tlast;

	// stage 1
	logic                     st1_valid;
	video_trim_pkg::pixel_t   st1_tdata;
	logic                     st1_tuser;
	logic                     st1_enable;
	video_trim_pkg::x_coord_t st1_x;
	video_trim_pkg::y_coord_t st1_y;
	logic                     line_done;

	// stage 2
	logic                     st2_valid;
	video_trim_pkg::pixel_t   st2_tdata;
	logic                     st2_tuser;
	logic                     st2_tlast;
	logic                     sof_pending;

	logic                     x_inside;
	logic                     y_inside;
	logic                     st1_keep;
	logic                     sof_now;

	// ----------------------------------------------------------
	// window test on the stage-1 pixel
	// ----------------------------------------------------------
	assign x_inside = (st1_x >= x_start) && (st1_x <= x_end);
	assign y_inside = (st1_y >= y_start) && (st1_y <= y_end);
	assign st1_keep = st1_valid && st1_enable && x_inside && y_inside;
	// frame start seen but not yet carried by a kept pixel
	assign sof_now  = st1_tuser || sof_pending;

	// ----------------------------------------------------------
	// control: valids, counters, sampled enable
	// ----------------------------------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			st0_valid   <= 1'b0;
			st1_valid   <= 1'b0;
			st2_valid   <= 1'b0;
			st1_enable  <= 1'b0;
			st1_x       <= '0;
			st1_y       <= '0;
			line_done   <= 1'b0;
			sof_pending <= 1'b0;
		end else if (advance) begin
			st0_valid <= s_tvalid;
			st1_valid <= st0_valid;
			st2_valid <= st1_keep;

			if (st0_valid) begin
				line_done <= st0_tlast;
				if (st0_tuser) begin
					st1_enable <= enable;
					st1_x      <= '0;
					st1_y      <= '0;
				end else if (line_done) begin
					st1_x <= '0;
					st1_y <= st1_y + 1'b1;
				end else begin
					st1_x <= st1_x + 1'b1;
				end
			end

			if (st1_valid) begin
				sof_pending <= st1_keep ? 1'b0 : sof_now;
			end
		end
	end

	// payload moves with the same advance
	always_ff @(posedge aclk) begin
		if (advance) begin
			st0_tdata <= s_tdata;
			st0_tuser <= s_tuser;
			st0_tlast <= s_tlast;
			st1_tdata <= st0_tdata;
			st1_tuser <= st0_tuser;
			st2_tdata <= st1_tdata;
			st2_tuser <= sof_now;
			st2_tlast <= (st1_x == x_end);
		end
	end

	assign out_valid = st2_valid;
	assign out_tdata = st2_tdata;
	assign out_tuser = st2_tuser;
	assign out_tlast = st2_tlast;

	// a stalled pipeline cannot produce a new beat
	assert property (@(posedge aclk) disable iff (!aresetn)
		!advance && !out_valid |=> !out_valid)
		else $error("out_valid rose while advance was low");

endmodule

`default_nettype wire

//--- hdl/pipeline_skid_buffer.sv
/*
 * two-entry skid buffer
 * output register plus skid register, ready to upstream is registered
 */

`timescale 1ns/1ps
`default_nettype none

module pipeline_skid_buffer #(
	parameter int DATA_WIDTH = 8
) (
	input  wire                   aclk,
	input  wire                   aresetn,
	input  wire                   s_valid,
	output logic                  s_ready,
	input  wire  [DATA_WIDTH-1:0] s_data,
	output logic                  m_valid,
	input  wire                   m_ready,
	output logic [DATA_WIDTH-1:0] m_data
);

	video_trim_pkg::buf_state_e state;
	video_trim_pkg::buf_state_e state_next;
	logic [DATA_WIDTH-1:0]      skid_data;
	logic                       push;
	logic                       pop;

	assign push = s_valid && s_ready;
	assign pop  = m_valid && m_ready;

	always_comb begin
		state_next = state;
		case (state)
			video_trim_pkg::BUF_EMPTY: if (push) state_next = video_trim_pkg::BUF_ONE;
			video_trim_pkg::BUF_ONE: begin
				if (push && !pop)
					state_next = video_trim_pkg::BUF_FULL;
				else if (!push && pop)
					state_next = video_trim_pkg::BUF_EMPTY;
			end
			video_trim_pkg::BUF_FULL: if (pop) state_next = video_trim_pkg::BUF_ONE;
			default: state_next = video_trim_pkg::BUF_EMPTY;
		endcase
	end

	// flags are decoded from the next state so both come out of flops
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state   <= video_trim_pkg::BUF_EMPTY;
			m_valid <= 1'b0;
			s_ready <= 1'b1;
		end else begin
			state   <= state_next;
			m_valid <= (state_next != video_trim_pkg::BUF_EMPTY);
			s_ready <= (state_next != video_trim_pkg::BUF_FULL);
		end
	end

	always_ff @(posedge aclk) begin
		case (state)
			video_trim_pkg::BUF_EMPTY: if (push) m_data <= s_data;
			video_trim_pkg::BUF_ONE: begin
				if (push && pop)
					m_data <= s_data;
				else if (push)
					skid_data <= s_data;
			end
			// drain the skid entry into the output
			video_trim_pkg::BUF_FULL: if (pop) m_data <= skid_data;
			default: ;
		endcase
	end

	assert property (@(posedge aclk) disable iff (!aresetn)
		m_valid && !m_ready |=> m_valid && $stable(m_data))
		else $error("output beat changed while stalled");

endmodule

`default_nettype wire

//--- hdl/video_trim_top.sv
/*
 * video window trimmer top
 * config registers, trim core and output skid buffer
 */

`timescale 1ns/1ps
`default_nettype none

module video_trim_top (
	input  wire                             aclk,
	input  wire                             aresetn,
	input  wire                             cfg_valid,
	output logic                            cfg_ready,
	input  wire video_trim_pkg::cfg_op_e    cfg_op,
	input  wire [video_trim_pkg::CFG_DATA_WIDTH-1:0] cfg_data,
	input  wire                             s_tvalid,
	output logic                            s_tready,
	input  wire video_trim_pkg::pixel_t     s_tdata,
	input  wire                             s_tuser,
	input  wire                             s_tlast,
	output logic                            m_tvalid,
	input  wire                             m_tready,
	output video_trim_pkg::pixel_t          m_tdata,
	output logic                            m_tuser,
	output logic                            m_tlast
);

	// live window parameters
	logic                     live_enable;
	video_trim_pkg::x_coord_t live_x_start;
	video_trim_pkg::x_coord_t live_x_end;
	video_trim_pkg::y_coord_t live_y_start;
	video_trim_pkg::y_coord_t live_y_end;

	// core stage 2 towards the buffer
	logic                     core_valid;
	video_trim_pkg::pixel_t   core_tdata;
	logic                     core_tuser;
	logic                     core_tlast;

	trim_param_regs u_param_regs (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.cfg_valid (cfg_valid),
		.cfg_ready (cfg_ready),
		.cfg_op    (cfg_op),
		.cfg_data  (cfg_data),
		.enable    (live_enable),
		.x_start   (live_x_start),
		.x_end     (live_x_end),
		.y_start   (live_y_start),
		.y_end     (live_y_end)
	);

	// buffer ready stalls the whole core and is also the input ready
	video_trim_core u_core (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.enable    (live_enable),
		.x_start   (live_x_start),
		.x_end     (live_x_end),
		.y_start   (live_y_start),
		.y_end     (live_y_end),
		.s_tvalid  (s_tvalid),
		.s_tdata   (s_tdata),
		.s_tuser   (s_tuser),
		.s_tlast   (s_tlast),
		.advance   (s_tready),
		.out_valid (core_valid),
		.out_tdata (core_tdata),
		.out_tuser (core_tuser),
		.out_tlast (core_tlast)
	);

	pipeline_skid_buffer #(
		.DATA_WIDTH (video_trim_pkg::TDATA_WIDTH + 2)
	) u_skid (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_valid (core_valid),
		.s_ready (s_tready),
		.s_data  ({core_tuser, core_tlast, core_tdata}),
		.m_valid (m_tvalid),
		.m_ready (m_tready),
		.m_data  ({m_tuser, m_tlast, m_tdata})
	);

endmodule

`default_nettype wire

//--- verif/video_trim_tb.sv
/*
 * video window trimmer testbench
 * table of frames and windows, reference model, randomized gaps and stalls
 */

`timescale 1ns/1ps
`default_nettype none

module video_trim_tb;

	typedef enum logic [1:0] {BP_NONE, BP_GAPS, BP_STALLS, BP_BOTH} bp_mode_e;
	typedef logic [video_trim_pkg::CFG_DATA_WIDTH-1:0] cfg_word_t;

	typedef struct packed {
		logic [7:0]               width;
		logic [7:0]               height;
		logic                     enable;
		video_trim_pkg::x_coord_t x_start;
		video_trim_pkg::x_coord_t x_end;
		video_trim_pkg::y_coord_t y_start;
		video_trim_pkg::y_coord_t y_end;
		bp_mode_e                 mode;
		logic                     commit;
	} test_row_t;

	localparam int NUM_ROWS      = 8;
	localparam int CFG_TIMEOUT   = 20;
	localparam int FRAME_TIMEOUT = 4000;
	localparam int QUIET_CYCLES  = 16;

	// width, height, enable, x_start, x_end, y_start, y_end, mode, commit
	localparam test_row_t TEST_TABLE [NUM_ROWS] = '{
		'{8'd8,  8'd4, 1'b1, 12'd0, 12'd7,  12'd0, 12'd3, BP_NONE,   1'b1},
		'{8'd10, 8'd6, 1'b1, 12'd2, 12'd6,  12'd1, 12'd4, BP_NONE,   1'b1},
		'{8'd8,  8'd4, 1'b0, 12'd0, 12'd7,  12'd0, 12'd3, BP_NONE,   1'b1},
		'{8'd12, 8'd6, 1'b1, 12'd3, 12'd9,  12'd1, 12'd4, BP_STALLS, 1'b1},
		'{8'd12, 8'd6, 1'b1, 12'd0, 12'd11, 12'd2, 12'd5, BP_GAPS,   1'b1},
		'{8'd16, 8'd8, 1'b1, 12'd1, 12'd14, 12'd0, 12'd7, BP_BOTH,   1'b1},
		'{8'd16, 8'd8, 1'b1, 12'd4, 12'd8,  12'd2, 12'd3, BP_BOTH,   1'b0},
		'{8'd16, 8'd8, 1'b1, 12'd4, 12'd8,  12'd2, 12'd3, BP_BOTH,   1'b1}
	};
	string row_names [NUM_ROWS] = '{"full_frame", "interior", "disabled", "output_stalls",
		"input_gaps", "gaps_and_stalls", "staged_only", "staged_commit"};

	logic                     aclk;
	logic                     aresetn;
	logic                     cfg_valid;
	logic                     cfg_ready;
	video_trim_pkg::cfg_op_e  cfg_op;
	cfg_word_t                cfg_data;
	logic                     s_tvalid;
	logic                     s_tready;
	video_trim_pkg::pixel_t   s_tdata;
	logic                     s_tuser;
	logic                     s_tlast;
	logic                     m_tvalid;
	logic                     m_tready;
	video_trim_pkg::pixel_t   m_tdata;
	logic                     m_tuser;
	logic                     m_tlast;

	// committed window as the model sees it
	logic                     model_enable;
	video_trim_pkg::x_coord_t model_x_start;
	video_trim_pkg::x_coord_t model_x_end;
	video_trim_pkg::y_coord_t model_y_start;
	video_trim_pkg::y_coord_t model_y_end;

	video_trim_pkg::pixel_t   exp_data [$];
	logic                     exp_user [$];
	logic                     exp_last [$];
	logic [31:0]              lfsr_state;

	video_trim_top u_video_trim_top (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.cfg_valid (cfg_valid),
		.cfg_ready (cfg_ready),
		.cfg_op    (cfg_op),
		.cfg_data  (cfg_data),
		.s_tvalid  (s_tvalid),
		.s_tready  (s_tready),
		.s_tdata   (s_tdata),
		.s_tuser   (s_tuser),
		.s_tlast   (s_tlast),
		.m_tvalid  (m_tvalid),
		.m_tready  (m_tready),
		.m_tdata   (m_tdata),
		.m_tuser   (m_tuser),
		.m_tlast   (m_tlast)
	);

	always #2 aclk = ~aclk;

	// ----------------------------------------------------------
	// random bits, x^32 + x^22 + x^2 + x + 1
	// ----------------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	function automatic logic take_bit();
		lfsr_state = lfsr_next(lfsr_state);
		return lfsr_state[0];
	endfunction

	// row in the upper half, column in the lower half
	function automatic video_trim_pkg::pixel_t pixel_at(input video_trim_pkg::x_coord_t x,
		input video_trim_pkg::y_coord_t y);
		return {y, x};
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_pixel(input string test_name, input video_trim_pkg::pixel_t expected,
		input video_trim_pkg::pixel_t actual);
		if (actual !== expected)
			abort_run($sformatf("Error: %s tdata expected %h actual %h", test_name, expected,
				actual));
	endtask

	task automatic check_flag(input string test_name, input string flag_name,
		input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("Error: %s %s expected %b actual %b", test_name, flag_name,
				expected, actual));
	endtask

	// called just after a rising edge, returns just after the accepting edge
	task automatic write_cfg(input video_trim_pkg::cfg_op_e op, input cfg_word_t data);
		int waited;
		waited = 0;
		cfg_valid = 1'b1;
		cfg_op    = op;
		cfg_data  = data;
		while (!cfg_ready) begin
			@(posedge aclk);
			#1;
			waited++;
			if (waited > CFG_TIMEOUT)
				abort_run("config write was never accepted");
		end
		@(posedge aclk);
		#1;
		cfg_valid = 1'b0;
	endtask

	task automatic build_expected(input int width, input int height);
		int  x;
		int  y;
		logic first;
		exp_data.delete();
		exp_user.delete();
		exp_last.delete();
		first = 1'b1;
		for (y = 0; y < height; y++) begin
			for (x = 0; x < width; x++) begin
				if (model_enable && x >= int'(model_x_start) && x <= int'(model_x_end) &&
					y >= int'(model_y_start) && y <= int'(model_y_end)) begin
					exp_data.push_back(pixel_at(video_trim_pkg::x_coord_t'(x),
						video_trim_pkg::y_coord_t'(y)));
					exp_user.push_back(first);
					exp_last.push_back(x == int'(model_x_end));
					first = 1'b0;
				end
			end
		end
	endtask

	task automatic drive_pixel(input int idx, input int width);
		int x;
		int y;
		x = idx % width;
		y = idx / width;
		s_tvalid = 1'b1;
		s_tdata  = pixel_at(video_trim_pkg::x_coord_t'(x), video_trim_pkg::y_coord_t'(y));
		s_tuser  = (idx == 0);
		s_tlast  = (x == width - 1);
	endtask

	// ----------------------------------------------------------
	// one frame in, kept pixels out, then a quiet window
	// ----------------------------------------------------------
	task automatic stream_frame(input string name, input test_row_t row);
		int   total;
		int   in_idx;
		int   out_idx;
		int   cycles;
		logic holding;
		logic gaps;
		logic stalls;
		total   = int'(row.width) * int'(row.height);
		in_idx  = 0;
		out_idx = 0;
		cycles  = 0;
		holding = 1'b0;
		gaps    = (row.mode == BP_GAPS) || (row.mode == BP_BOTH);
		stalls  = (row.mode == BP_STALLS) || (row.mode == BP_BOTH);
		while (in_idx < total || out_idx < exp_data.size()) begin
			@(posedge aclk);
			#1;
			cycles++;
			if (cycles > FRAME_TIMEOUT)
				abort_run($sformatf("%s: frame did not complete in time", name));
			// a beat that was offered stays on the bus until taken
			if (!holding) begin
				if (in_idx < total && !(gaps && take_bit()))
					drive_pixel(in_idx, int'(row.width));
				else
					s_tvalid = 1'b0;
			end
			holding = s_tvalid && !s_tready;
			if (s_tvalid && s_tready)
				in_idx++;
			m_tready = stalls ? take_bit() : 1'b1;
			if (m_tvalid && m_tready) begin
				if (out_idx >= exp_data.size())
					abort_run($sformatf("%s: more output beats than kept pixels", name));
				check_pixel(name, exp_data[out_idx], m_tdata);
				check_flag(name, "tuser", exp_user[out_idx], m_tuser);
				check_flag(name, "tlast", exp_last[out_idx], m_tlast);
				out_idx++;
			end
		end
		repeat (QUIET_CYCLES) begin
			@(posedge aclk);
			#1;
			s_tvalid = 1'b0;
			if (m_tvalid)
				abort_run($sformatf("%s: output beat after the frame was complete", name));
			m_tready = 1'b1;
		end
		$display("%s: %0d of %0d pixels kept", name, out_idx, total);
	endtask

	task automatic run_row(input int idx);
		test_row_t row;
		row = TEST_TABLE[idx];
		write_cfg(video_trim_pkg::CFG_ENABLE, cfg_word_t'(row.enable));
		write_cfg(video_trim_pkg::CFG_X_START, cfg_word_t'(row.x_start));
		write_cfg(video_trim_pkg::CFG_X_END, cfg_word_t'(row.x_end));
		write_cfg(video_trim_pkg::CFG_Y_START, cfg_word_t'(row.y_start));
		write_cfg(video_trim_pkg::CFG_Y_END, cfg_word_t'(row.y_end));
		if (row.commit) begin
			write_cfg(video_trim_pkg::CFG_COMMIT, '0);
			model_enable  = row.enable;
			model_x_start = row.x_start;
			model_x_end   = row.x_end;
			model_y_start = row.y_start;
			model_y_end   = row.y_end;
		end
		build_expected(int'(row.width), int'(row.height));
		stream_frame(row_names[idx], row);
	endtask

	initial begin
		int idx;
		aclk          = 1'b0;
		aresetn       = 1'b0;
		cfg_valid     = 1'b0;
		cfg_op        = video_trim_pkg::CFG_ENABLE;
		cfg_data      = '0;
		s_tvalid      = 1'b0;
		s_tdata       = '0;
		s_tuser       = 1'b0;
		s_tlast       = 1'b0;
		m_tready      = 1'b0;
		lfsr_state    = 32'h5bea;
		model_enable  = 1'b0;
		model_x_start = '0;
		model_x_end   = '0;
		model_y_start = '0;
		model_y_end   = '0;
		repeat (5) @(posedge aclk);
		#1;
		aresetn = 1'b1;
		for (idx = 0; idx < NUM_ROWS; idx++)
			run_row(idx);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hdl/video_trim_pkg.sv
hdl/trim_param_regs.sv
hdl/video_trim_core.sv
hdl/pipeline_skid_buffer.sv
hdl/video_trim_top.sv
verif/video_trim_tb.sv

//--- Makefile
# Verilator simulation of the video window trimmer

VERILATOR ?= verilator
TOP       ?= video_trim_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG_FILE  ?= sim.log
PASS_TEXT ?= Testbench passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# the log decides the status, since the pipe hides the simulator's own
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG_FILE)
	grep -q "$(PASS_TEXT)" $(LOG_FILE)

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)
